// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/1ps

// two cpu ports sharing one sdram bank
// port 0 has priority at the arbiter
module mem_subsys_top
    import sdram_rq_pkg::*;
(
    input  logic        rst,
    input  logic        clk,
    input  cpu_addr_t   addr0,
    input  cpu_addr_t   addr1,
    input  sdram_addr_t offset0,
    input  sdram_addr_t offset1,
    input  logic        addr_ok0,
    input  logic        addr_ok1,
    input  logic        wrin0,
    input  logic        wrin1,
    input  cpu_data_t   wrdata0,
    input  cpu_data_t   wrdata1,
    output logic        data_ok0,
    output logic        data_ok1,
    output cpu_data_t   dout0,
    output cpu_data_t   dout1
);

    // request blocks to arbiter
    logic [NPORTS-1:0] port_req;
    logic [NPORTS-1:0] port_rnw;
    logic [NPORTS-1:0] sel;
    sdram_addr_t       port_addr0;
    sdram_addr_t       port_addr1;
    sdram_data_t       port_wdata0;
    sdram_data_t       port_wdata1;

    // arbiter to controller
    logic              ctrl_req;
    logic              ctrl_rnw;
    sdram_addr_t       ctrl_addr;
    sdram_data_t       ctrl_wdata;
    logic              ready;
    logic              dst;        // seen by both blocks, only the selected one acts
    sdram_data_t       rd_data;

    ram_rq rq0 (
        .rst        (rst),
        .clk        (clk),
        .addr       (addr0),
        .offset     (offset0),
        .addr_ok    (addr_ok0),
        .wrin       (wrin0),
        .wrdata     (wrdata0),
        .we         (sel[0]),
        .dst        (dst),
        .din        (rd_data),
        .req        (port_req[0]),
        .req_rnw    (port_rnw[0]),
        .sdram_addr (port_addr0),
        .wr_word    (port_wdata0),
        .data_ok    (data_ok0),
        .dout       (dout0)
    );

    ram_rq rq1 (
        .rst        (rst),
        .clk        (clk),
        .addr       (addr1),
        .offset     (offset1),
        .addr_ok    (addr_ok1),
        .wrin       (wrin1),
        .wrdata     (wrdata1),
        .we         (sel[1]),
        .dst        (dst),
        .din        (rd_data),
        .req        (port_req[1]),
        .req_rnw    (port_rnw[1]),
        .sdram_addr (port_addr1),
        .wr_word    (port_wdata1),
        .data_ok    (data_ok1),
        .dout       (dout1)
    );

    sdram_arbiter arb0 (
        .rst         (rst),
        .clk         (clk),
        .port_req    (port_req),
        .port_rnw    (port_rnw),
        .port_addr0  (port_addr0),
        .port_addr1  (port_addr1),
        .port_wdata0 (port_wdata0),
        .port_wdata1 (port_wdata1),
        .ready       (ready),
        .dst         (dst),
        .sel         (sel),
        .ctrl_req    (ctrl_req),
        .ctrl_rnw    (ctrl_rnw),
        .ctrl_addr   (ctrl_addr),
        .ctrl_wdata  (ctrl_wdata)
    );

    sdram_bank_ctrl ctrl0 (
        .rst        (rst),
        .clk        (clk),
        .ctrl_req   (ctrl_req),
        .ctrl_rnw   (ctrl_rnw),
        .ctrl_addr  (ctrl_addr),
        .ctrl_wdata (ctrl_wdata),
        .ready      (ready),
        .dst        (dst),
        .rd_data    (rd_data)
    );

endmodule

// ==== hdl/ram_rq.sv ====
`timescale 1ns/1ps

// one request per rising edge of addr_ok (the chip select)
// data_ok stays up until the cpu lets go of addr_ok
module ram_rq
    import sdram_rq_pkg::*;
(
    input  logic        rst,
    input  logic        clk,
    input  cpu_addr_t   addr,
    input  sdram_addr_t offset,     // static bank base
    input  logic        addr_ok,    // chip select level from the decoder
    input  logic        wrin,       // high for a write
    input  cpu_data_t   wrdata,
    input  logic        we,         // port selected by the arbiter
    input  logic        dst,        // data strobe from the controller
    input  sdram_data_t din,
    output logic        req,
    output logic        req_rnw,
    output sdram_addr_t sdram_addr,
    output sdram_data_t wr_word,
    output logic        data_ok,
    output cpu_data_t   dout
);

    logic        last_cs;       // addr_ok one cycle back
    logic        pend;          // request waiting for a grant
    logic        cs_posedge;
    logic        cs_negedge;
    sdram_addr_t addr_ext;      // cpu address widened to the sdram space

    assign addr_ext   = {{(SDRAMW-AW){1'b0}}, addr};
    assign cs_posedge = addr_ok & ~last_cs;
    assign cs_negedge = ~addr_ok & last_cs;

    // drops in the very first cycle of the grant
    assign req = pend & ~we;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_cs <= 1'b0;
            pend    <= 1'b0;
            data_ok <= 1'b0;
        end else begin
            last_cs <= addr_ok;
            if (cs_negedge) data_ok <= 1'b0;   // cpu has seen the data
            if (we) begin
                pend <= 1'b0;                  // granted, nothing left to ask
                if (dst) data_ok <= 1'b1;      // reads and writes alike
            end
            if (cs_posedge) begin
                pend    <= 1'b1;
                data_ok <= 1'b0;
            end
        end
    end

    // request payload, held steady while pend is up
    always_ff @(posedge clk) begin
        if (cs_posedge) begin
            sdram_addr <= addr_ext + offset;
            req_rnw    <= ~wrin;
            wr_word    <= {{($bits(sdram_data_t)-DW){1'b0}}, wrdata}; // byte in low half
        end
        if (we && dst) dout <= din[DW-1:0];    // only the low byte goes back
    end

    // the arbiter only selects a port that was requesting the cycle before
    a_grant_follows_req: assert property (@(posedge clk) disable iff (rst)
        $rose(we) |-> $past(req));

endmodule

// ==== hdl/sdram_arbiter.sv ====
`timescale 1ns/1ps

// fixed priority, port 0 first
// one request in flight at a time, held until the controller strobes dst
module sdram_arbiter
    import sdram_rq_pkg::*;
(
    input  logic              rst,
    input  logic              clk,
    input  logic [NPORTS-1:0] port_req,
    input  logic [NPORTS-1:0] port_rnw,
    input  sdram_addr_t       port_addr0,
    input  sdram_addr_t       port_addr1,
    input  sdram_data_t       port_wdata0,
    input  sdram_data_t       port_wdata1,
    input  logic              ready,        // controller can take ctrl_req next cycle
    input  logic              dst,
    output logic [NPORTS-1:0] sel,          // per port select level
    output logic              ctrl_req,     // single cycle
    output logic              ctrl_rnw,
    output sdram_addr_t       ctrl_addr,
    output sdram_data_t       ctrl_wdata
);

    arb_state_t                state;
    logic [$clog2(NPORTS)-1:0] gnt_idx;     // winning port
    logic                      gnt_any;     // some port is asking
    logic                      grant;

    // scan from the top so the lowest index is left standing
    always_comb begin
        gnt_idx = '0;
        gnt_any = 1'b0;
        for (int i = NPORTS - 1; i >= 0; i--) begin
            if (port_req[i]) begin
                gnt_idx = $clog2(NPORTS)'(i);
                gnt_any = 1'b1;
            end
        end
    end

    assign grant = (state == ARB_IDLE) && ready && gnt_any;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ARB_IDLE;
            sel      <= '0;
            ctrl_req <= 1'b0;
        end else begin
            ctrl_req <= 1'b0;                   // pulse only
            case (state)
                ARB_IDLE: begin
                    if (grant) begin
                        state        <= ARB_BUSY;
                        sel          <= '0;
                        sel[gnt_idx] <= 1'b1;
                        ctrl_req     <= 1'b1;
                    end
                end
                ARB_BUSY: begin
                    if (dst) begin              // sel falls the cycle after dst
                        state <= ARB_IDLE;
                        sel   <= '0;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // request payload taken with the grant
    always_ff @(posedge clk) begin
        if (grant) begin
            ctrl_rnw   <= port_rnw[gnt_idx];
            ctrl_addr  <= (gnt_idx == 1'b1) ? port_addr1 : port_addr0;
            ctrl_wdata <= (gnt_idx == 1'b1) ? port_wdata1 : port_wdata0;
        end
    end

    // a strobe with nothing outstanding means the controller lost track
    a_dst_when_busy: assert property (@(posedge clk) disable iff (rst)
        dst |-> state == ARB_BUSY);

endmodule

// ==== hdl/sdram_bank_ctrl.sv ====
`timescale 1ns/1ps

// stands in for the sdram bank
// fixed access delay, periodic refresh stalls and an on-chip word array
module sdram_bank_ctrl
    import sdram_rq_pkg::*;
(
    input  logic        rst,
    input  logic        clk,
    input  logic        ctrl_req,
    input  logic        ctrl_rnw,
    input  sdram_addr_t ctrl_addr,
    input  sdram_data_t ctrl_wdata,
    output logic        ready,
    output logic        dst,
    output sdram_data_t rd_data
);

    typedef logic [$clog2(REF_LEN + ACC_LAT)-1:0] cnt_t;
    typedef logic [$clog2(REF_PERIOD + 1)-1:0]    ref_cnt_t;

    ctrl_state_t       state;
    cnt_t              cnt;         // countdown shared by access and refresh
    ref_cnt_t          ref_cnt;     // cycles since the last refresh, saturates
    logic              ref_due;
    logic              init_busy;   // clearing sweep after reset
    logic [MEM_AW-1:0] sweep_addr;
    logic              accept;
    logic [MEM_AW-1:0] mem_addr;
    sdram_data_t       mem [2**MEM_AW];

    assign ref_due = (ref_cnt == ref_cnt_t'(REF_PERIOD));

    // ready drops a cycle ahead of a refresh window,
    // so a ctrl_req already on its way still finds the state idle
    assign ready = (state == CTRL_IDLE) && !init_busy && !ref_due;

    assign accept   = (state == CTRL_IDLE) && ctrl_req && !init_busy;
    assign mem_addr = init_busy ? sweep_addr : ctrl_addr[MEM_AW-1:0]; // upper bits ignored

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= CTRL_IDLE;
            cnt        <= '0;
            ref_cnt    <= '0;
            init_busy  <= 1'b1;
            sweep_addr <= '0;
            dst        <= 1'b0;
        end else begin
            dst <= 1'b0;

            // one word cleared per cycle
            if (init_busy) begin
                sweep_addr <= sweep_addr + 1'b1;
                if (&sweep_addr) init_busy <= 1'b0;
            end

            // restart the interval while refreshing
            if (state == CTRL_REFRESH) begin
                ref_cnt <= '0;
            end else if (!ref_due) begin
                ref_cnt <= ref_cnt + 1'b1;
            end

            case (state)
                CTRL_IDLE: begin
                    if (accept) begin                       // request beats refresh
                        state <= CTRL_ACCESS;
                        cnt   <= cnt_t'(ACC_LAT - 2);
                    end else if (ref_due && !init_busy) begin
                        state <= CTRL_REFRESH;
                        cnt   <= cnt_t'(REF_LEN - 1);
                    end
                end
                CTRL_ACCESS: begin
                    if (cnt == '0) begin
                        dst   <= 1'b1;                      // ACC_LAT after ctrl_req
                        state <= CTRL_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                CTRL_REFRESH: begin
                    if (cnt == '0) state <= CTRL_IDLE;
                    else cnt <= cnt - 1'b1;
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

    // word array and read port
    always_ff @(posedge clk) begin
        if (init_busy) begin
            mem[mem_addr] <= '0;
        end else if (accept && !ctrl_rnw) begin
            mem[mem_addr] <= ctrl_wdata;
        end
        if (accept) begin
            rd_data <= ctrl_rnw ? mem[mem_addr] : ctrl_wdata;  // write echoes its word
        end
    end

    // the arbiter decides on ready one cycle before ctrl_req shows up
    a_req_after_ready: assert property (@(posedge clk) disable iff (rst)
        ctrl_req |-> $past(ready) && state == CTRL_IDLE);

endmodule

// ==== hdl/sdram_rq_pkg.sv ====
package sdram_rq_pkg;

    // address and data widths
    localparam int SDRAMW = 22;     // sdram word address
    localparam int AW     = 18;     // cpu side address
    localparam int DW     = 8;      // cpu side data
    localparam int MEM_AW = 12;     // address bits the on-chip array decodes
    localparam int NPORTS = 2;      // request blocks sharing the controller

    // controller timing in clk cycles
    localparam int ACC_LAT    = 4;  // accept to dst, must be 2 or more
    localparam int REF_PERIOD = 64; // gap from one refresh window to the next
    localparam int REF_LEN    = 6;  // length of a refresh window

    // address types
    typedef logic [SDRAMW-1:0] sdram_addr_t;
    typedef logic [AW-1:0]     cpu_addr_t;

    // data types, sdram word is always 16 bits
    typedef logic [DW-1:0]     cpu_data_t;
    typedef logic [15:0]       sdram_data_t;

    // arbiter: idle waits for a request, busy waits for dst
    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_t;

    // bank controller
    typedef enum logic [1:0] {
        CTRL_IDLE,      // ready for a request
        CTRL_ACCESS,    // counting down to dst
        CTRL_REFRESH    // refresh window, ready low
    } ctrl_state_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys \
    -f vlog.f -o tb_mem_subsys > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_mem_subsys > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || grep -q "Simulation passed" sim.log || exit 1
exit 0

// ==== tb/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// byte compare against the expected value of the running test
task automatic check_byte(input cpu_data_t exp, input cpu_data_t act);
    assert (act === exp) else begin
        errors++;
        $display("Mismatch in %s: expected %h, actual %h", cur_test, exp, act);
    end
endtask

// a condition that has to hold, with a description of what went wrong
task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
        errors++;
        $display("%s: %s", cur_test, what);
    end
endtask

task automatic start_test(input string name);
    cur_test = name;
    err_mark = errors;      // errors seen before this test
endtask

task automatic finish_test();
    tests_run++;
    if (errors > err_mark) begin
        tests_failed++;
        $display("test %s: FAILED, %0d checks failed", cur_test, errors - err_mark);
    end else begin
        $display("test %s: ok", cur_test);
    end
endtask

// once up, data_ok stays up as long as the cpu holds addr_ok
a_hold0: assert property (@(posedge clk) disable iff (rst)
    (data_ok0 && addr_ok0) |=> data_ok0)
    else begin
        errors++;
        $display("%s: data_ok0 dropped while addr_ok0 was still high", cur_test);
    end

a_hold1: assert property (@(posedge clk) disable iff (rst)
    (data_ok1 && addr_ok1) |=> data_ok1)
    else begin
        errors++;
        $display("%s: data_ok1 dropped while addr_ok1 was still high", cur_test);
    end

// release seen one edge later, so data_ok is down by the edge after that
a_release0: assert property (@(posedge clk) disable iff (rst)
    $fell(addr_ok0) |=> !data_ok0)
    else begin
        errors++;
        $display("%s: data_ok0 still high after addr_ok0 fell", cur_test);
    end

a_release1: assert property (@(posedge clk) disable iff (rst)
    $fell(addr_ok1) |=> !data_ok1)
    else begin
        errors++;
        $display("%s: data_ok1 still high after addr_ok1 fell", cur_test);
    end

// idle port never reports data
a_idle0: assert property (@(posedge clk) disable iff (rst)
    (!addr_ok0 && !$past(addr_ok0)) |-> !data_ok0)
    else begin
        errors++;
        $display("%s: data_ok0 high with addr_ok0 low", cur_test);
    end

a_idle1: assert property (@(posedge clk) disable iff (rst)
    (!addr_ok1 && !$past(addr_ok1)) |-> !data_ok1)
    else begin
        errors++;
        $display("%s: data_ok1 high with addr_ok1 low", cur_test);
    end

`endif

// ==== tb/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys
    import sdram_rq_pkg::*;
();

    localparam int N_RANDOM = 200;
    localparam int N_ACCESS = N_RANDOM + 20;   // directed tests stay well under 20
    // worst case per access, doubled, plus the clearing sweep after reset
    localparam int WATCHDOG_CYCLES = N_ACCESS * (ACC_LAT + REF_LEN + 12) * 2
                                     + 2**MEM_AW + 200;

    logic        clk;
    logic        rst;
    cpu_addr_t   addr0;
    cpu_addr_t   addr1;
    sdram_addr_t offset0;
    sdram_addr_t offset1;
    logic        addr_ok0;
    logic        addr_ok1;
    logic        wrin0;
    logic        wrin1;
    cpu_data_t   wrdata0;
    cpu_data_t   wrdata1;
    logic        data_ok0;
    logic        data_ok1;
    cpu_data_t   dout0;
    cpu_data_t   dout1;

    int          errors = 0;
    int          err_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       cur_test = "none";
    integer      seed = 32'h33fd_9343;
    cpu_data_t   shadow [2**MEM_AW];   // expected byte per array word

    `include "tb_checks.svh"

    initial clk = 1'b0;
    always #20 clk = ~clk;             // 40 ns period

    mem_subsys_top dut0 (
        .rst      (rst),
        .clk      (clk),
        .addr0    (addr0),
        .addr1    (addr1),
        .offset0  (offset0),
        .offset1  (offset1),
        .addr_ok0 (addr_ok0),
        .addr_ok1 (addr_ok1),
        .wrin0    (wrin0),
        .wrin1    (wrin1),
        .wrdata0  (wrdata0),
        .wrdata1  (wrdata1),
        .data_ok0 (data_ok0),
        .data_ok1 (data_ok1),
        .dout0    (dout0),
        .dout1    (dout1)
    );

    function automatic logic dok(input int port);
        return (port == 0) ? data_ok0 : data_ok1;
    endfunction

    // zero-extended address plus the port's bank base, wrapped to the array
    function automatic int shadow_idx(input int port, input cpu_addr_t a);
        sdram_addr_t full;
        full = sdram_addr_t'(a) + ((port == 0) ? offset0 : offset1);
        return int'(full[MEM_AW-1:0]);
    endfunction

    task automatic drive_port(input int port, input logic cs, input logic wr,
                              input cpu_addr_t a, input cpu_data_t d);
        if (port == 0) begin
            addr0    = a;
            wrin0    = wr;
            wrdata0  = d;
            addr_ok0 = cs;
        end else begin
            addr1    = a;
            wrin1    = wr;
            wrdata1  = d;
            addr_ok1 = cs;
        end
    endtask

    // one chip-select cycle, hold keeps addr_ok up that many cycles past data_ok
    task automatic access(input int port, input logic wr, input cpu_addr_t a,
                          input cpu_data_t d, input int hold,
                          output cpu_data_t q, output int lat);
        int fall;
        @(negedge clk);
        drive_port(port, 1'b1, wr, a, d);
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!dok(port));
        q = (port == 0) ? dout0 : dout1;    // stable between edges
        repeat (hold) @(negedge clk);
        drive_port(port, 1'b0, wr, a, d);
        fall = 0;
        do begin
            @(negedge clk);
            fall++;
        end while (dok(port));
        check_true(lat >= ACC_LAT + 3, "data_ok rose sooner than the access delay allows");
        check_true(fall <= 2, "data_ok stayed high over 2 cycles after addr_ok fell");
    endtask

    task automatic write_byte(input int port, input cpu_addr_t a, input cpu_data_t d,
                              input int hold);
        cpu_data_t q;
        int        lat;
        access(port, 1'b1, a, d, hold, q, lat);
        shadow[shadow_idx(port, a)] = d;
    endtask

    task automatic read_check(input int port, input cpu_addr_t a, input int hold,
                              output int lat);
        cpu_data_t exp;
        cpu_data_t q;
        exp = shadow[shadow_idx(port, a)];
        access(port, 1'b0, a, 8'h00, hold, q, lat);
        check_byte(exp, q);
    endtask

    initial begin
        int        lat0;
        int        lat1;
        int        port;
        int        hold;
        cpu_data_t q;
        cpu_addr_t a;
        integer    rnd;
        rst      = 1'b1;
        addr0    = '0;
        addr1    = '0;
        offset0  = '0;
        offset1  = 22'h000456;         // port 1 bank base, static
        addr_ok0 = 1'b0;
        addr_ok1 = 1'b0;
        wrin0    = 1'b0;
        wrin1    = 1'b0;
        wrdata0  = '0;
        wrdata1  = '0;
        for (int i = 0; i < 2**MEM_AW; i++) shadow[i] = '0;   // matches the reset sweep
        repeat (4) @(negedge clk);
        rst = 1'b0;

        start_test("reset_idle");
        repeat (16) begin
            @(negedge clk);
            check_true(!data_ok0 && !data_ok1, "data_ok high with addr_ok low");
        end
        finish_test();

        start_test("write_read");
        write_byte(0, 18'h00010, 8'h5a, 0);
        read_check(0, 18'h00010, 0, lat0);
        access(0, 1'b0, 18'h00011, 8'h00, 0, q, lat0);
        check_byte(8'h00, q);                            // never written
        write_byte(0, 18'h00abc, 8'h3c, 0);
        read_check(0, 18'h00abc, 0, lat0);
        finish_test();

        start_test("offset_map");
        write_byte(1, 18'h00123, 8'ha7, 0);
        access(0, 1'b0, 18'h00579, 8'h00, 0, q, lat0);  // 0x123 + 0x456
        check_byte(8'ha7, q);
        finish_test();

        start_test("data_ok_hold");
        read_check(0, 18'h00010, 6, lat0);
        write_byte(1, 18'h00200, 8'h81, 4);
        read_check(1, 18'h00200, 3, lat1);
        finish_test();

        start_test("contention");
        write_byte(0, 18'h00040, 8'h11, 0);
        write_byte(1, 18'h00050, 8'h22, 0);
        fork
            read_check(0, 18'h00040, 0, lat0);
            read_check(1, 18'h00050, 0, lat1);
        join
        check_true(lat0 < lat1, "port 1 finished ahead of port 0 on a tie");
        finish_test();

        start_test("random_traffic");
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd  = $random(seed);
            port = int'(rnd[0]);
            hold = int'(rnd[3:2]);
            a    = cpu_addr_t'(rnd[31:14]) & 18'h3f03f;  // upper bits vary, 64 words hit
            if (rnd[1]) write_byte(port, a, rnd[11:4], hold);
            else read_check(port, a, hold, lat0);
        end
        finish_test();

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, an access never completed",
                 WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+tb
hdl/sdram_rq_pkg.sv
hdl/ram_rq.sv
hdl/sdram_arbiter.sv
hdl/sdram_bank_ctrl.sv
hdl/mem_subsys_top.sv
tb/tb_mem_subsys.sv
